//--- verilog/cpu_cfg.svh
`ifndef CPU_CFG_SVH
`define CPU_CFG_SVH

// datapath and address width
`define XLEN 64
`define INSTR_W 32

// architectural register file
`define REG_COUNT 32
`define REG_ADDR_W 5

// values loaded on reset
`define RESET_PC 64'h0000_0000_0000_0000
`define SP_INIT 64'h0000_0000_0000_1000

// shift amount bits, enough for 64-bit shifts
`define SHAMT_W 6

`endif

//--- verilog/cpuPkg.sv
`default_nettype none

package cpuPkg;

	// major opcodes, jal and jalr use the core's own encodings
	typedef enum logic [6:0] {
		opReg    = 7'b0110011,
		opImm    = 7'b0010011,
		opLoad   = 7'b0000011,
		opStore  = 7'b0100011,
		opBranch = 7'b1100011,
		opJal    = 7'b1111111,
		opJalr   = 7'b1110111,
		opLui    = 7'b0110111,
		opAuipc  = 7'b0010111
	} opcodeT;

	typedef enum logic [3:0] {
		aluAdd,
		aluSub,
		aluSll,
		aluSlt,
		aluSltu,
		aluSeq,
		aluSne,
		aluXor,
		aluSrl,
		aluSra,
		aluOr,
		aluAnd
	} aluOpT;

	// values line up with funct3 of loads and stores
	typedef enum logic [2:0] {
		memByte   = 3'b000,
		memHalf   = 3'b001,
		memWord   = 3'b010,
		memDouble = 3'b011,
		memByteU  = 3'b100,
		memHalfU  = 3'b101,
		memNone   = 3'b111 // no access
	} memSizeT;

endpackage

`default_nettype wire

//--- verilog/registerFile.sv
`default_nettype none
`include "cpu_cfg.svh"

module registerFile (
	input  logic                   clk,
	input  logic                   rst,
	input  logic [`REG_ADDR_W-1:0] rs1,
	input  logic [`REG_ADDR_W-1:0] rs2,
	input  logic [`REG_ADDR_W-1:0] rd,
	input  logic                   regWrite,
	input  logic [`XLEN-1:0]       writeData,
	output logic [`XLEN-1:0]       rs1Data,
	output logic [`XLEN-1:0]       rs2Data
);

	logic [`XLEN-1:0] regs [`REG_COUNT];

	assign rs1Data = regs[rs1];
	assign rs2Data = regs[rs2];

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			for (int i = 0; i < `REG_COUNT; i++) begin
				regs[i] <= (i == 2) ? `SP_INIT : '0; // x2 is sp
			end
		end else if (regWrite && rd != '0) begin // x0 stays zero
			regs[rd] <= writeData;
		end
	end

endmodule

`default_nettype wire

//--- verilog/alu.sv
`default_nettype none
`include "cpu_cfg.svh"

module alu (
	input  logic [`XLEN-1:0]   a,
	input  logic [`XLEN-1:0]   b,
	input  cpuPkg::aluOpT      op,
	output logic [`XLEN-1:0]   result
);

	logic [`SHAMT_W-1:0] shamt;

	assign shamt = b[`SHAMT_W-1:0];

	always_comb begin
		case (op)
			cpuPkg::aluAdd:  result = a + b;
			cpuPkg::aluSub:  result = a - b;
			cpuPkg::aluSll:  result = a << shamt;
			cpuPkg::aluSlt:  result = ($signed(a) < $signed(b)) ? `XLEN'd1 : `XLEN'd0;
			cpuPkg::aluSltu: result = (a < b) ? `XLEN'd1 : `XLEN'd0;
			cpuPkg::aluSeq:  result = (a == b) ? `XLEN'd1 : `XLEN'd0;
			cpuPkg::aluSne:  result = (a != b) ? `XLEN'd1 : `XLEN'd0;
			cpuPkg::aluXor:  result = a ^ b;
			cpuPkg::aluSrl:  result = a >> shamt;
			cpuPkg::aluSra:  result = $unsigned($signed(a) >>> shamt); // keeps sign
			cpuPkg::aluOr:   result = a | b;
			cpuPkg::aluAnd:  result = a & b;
			default:         result = '0;
		endcase
	end

endmodule

`default_nettype wire

//--- verilog/memFormat.sv
`default_nettype none
`include "cpu_cfg.svh"

module memFormat (
	input  cpuPkg::memSizeT    memSize,
	input  logic [`XLEN-1:0]   storeSrc,
	output logic [`XLEN-1:0]   dataOut,
	input  logic [`XLEN-1:0]   dataIn,
	output logic [`XLEN-1:0]   loadData
);

	// store lane goes out on every lane of the bus
	always_comb begin
		case (memSize)
			cpuPkg::memByte:   dataOut = {(`XLEN/8){storeSrc[7:0]}};
			cpuPkg::memHalf:   dataOut = {(`XLEN/16){storeSrc[15:0]}};
			cpuPkg::memWord:   dataOut = {(`XLEN/32){storeSrc[31:0]}};
			cpuPkg::memDouble: dataOut = storeSrc;
			default:           dataOut = '0;
		endcase
	end

	// low lane of the returned doubleword, then extend
	always_comb begin
		case (memSize)
			cpuPkg::memByte:   loadData = {{(`XLEN-8){dataIn[7]}}, dataIn[7:0]};
			cpuPkg::memHalf:   loadData = {{(`XLEN-16){dataIn[15]}}, dataIn[15:0]};
			cpuPkg::memWord:   loadData = {{(`XLEN-32){dataIn[31]}}, dataIn[31:0]};
			cpuPkg::memDouble: loadData = dataIn;
			cpuPkg::memByteU:  loadData = {{(`XLEN-8){1'b0}}, dataIn[7:0]};
			cpuPkg::memHalfU:  loadData = {{(`XLEN-16){1'b0}}, dataIn[15:0]};
			default:           loadData = '0;
		endcase
	end

endmodule

`default_nettype wire

//--- verilog/decoder.sv
`default_nettype none
`include "cpu_cfg.svh"

module decoder (
	input  logic [`INSTR_W-1:0]    instr,
	input  logic [`XLEN-1:0]       pc,
	output logic [`REG_ADDR_W-1:0] rs1,
	output logic [`REG_ADDR_W-1:0] rs2,
	input  logic [`XLEN-1:0]       rs1Data,
	input  logic [`XLEN-1:0]       rs2Data,
	output logic [`REG_ADDR_W-1:0] rd,
	output logic                   regWrite,
	output logic [`XLEN-1:0]       aluA,
	output logic [`XLEN-1:0]       aluB,
	output cpuPkg::aluOpT          aluOp,
	output logic                   memRead,
	output logic                   memWrite,
	output cpuPkg::memSizeT        memSize,
	output logic                   takeJump,
	output logic [`XLEN-1:0]       jumpTarget
);

	cpuPkg::opcodeT opcode;
	logic [2:0] funct3;
	logic [6:0] funct7;
	logic [5:0] funct6; // shift-immediate funct, shamt takes bit 25
	logic [`XLEN-1:0] immI, immS, immB, immU, immJ;
	logic regOk, immOk;
	cpuPkg::aluOpT regOp, immOp;

	assign opcode = cpuPkg::opcodeT'(instr[6:0]);
	assign funct3 = instr[14:12];
	assign funct7 = instr[31:25];
	assign funct6 = instr[31:26];
	assign rs1    = instr[19:15];
	assign rs2    = instr[24:20];

	assign immI = {{(`XLEN-12){instr[31]}}, instr[31:20]};
	assign immS = {{(`XLEN-12){instr[31]}}, instr[31:25], instr[11:7]};
	assign immB = {{(`XLEN-13){instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
	assign immU = {{(`XLEN-32){instr[31]}}, instr[31:12], 12'b0};
	assign immJ = {{(`XLEN-21){instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};

	// register-register funct decode
	always_comb begin
		regOk = 1'b1;
		case ({funct7, funct3})
			{7'b0000000, 3'b000}: regOp = cpuPkg::aluAdd;
			{7'b0110000, 3'b000}: regOp = cpuPkg::aluSub; // core's own sub encoding
			{7'b0000000, 3'b001}: regOp = cpuPkg::aluSll;
			{7'b0000000, 3'b010}: regOp = cpuPkg::aluSlt;
			{7'b0000001, 3'b010}: regOp = cpuPkg::aluSeq;
			{7'b0000010, 3'b010}: regOp = cpuPkg::aluSne;
			{7'b0000000, 3'b011}: regOp = cpuPkg::aluSltu;
			{7'b0000000, 3'b100}: regOp = cpuPkg::aluXor;
			{7'b0000000, 3'b101}: regOp = cpuPkg::aluSrl;
			{7'b0100000, 3'b101}: regOp = cpuPkg::aluSra;
			{7'b0000000, 3'b110}: regOp = cpuPkg::aluOr;
			{7'b0000000, 3'b111}: regOp = cpuPkg::aluAnd;
			default: begin
				regOk = 1'b0;
				regOp = cpuPkg::aluAdd;
			end
		endcase
	end

	// immediate funct decode
	always_comb begin
		immOk = 1'b1;
		immOp = cpuPkg::aluAdd;
		case (funct3)
			3'b000: immOp = cpuPkg::aluAdd;
			3'b010: immOp = cpuPkg::aluSlt;
			3'b011: immOp = cpuPkg::aluSltu;
			3'b100: immOp = cpuPkg::aluXor;
			3'b110: immOp = cpuPkg::aluOr;
			3'b111: immOp = cpuPkg::aluAnd;
			3'b001: begin
				immOp = cpuPkg::aluSll;
				immOk = (funct6 == 6'b000000);
			end
			default: begin // 3'b101
				immOp = (funct6 == 6'b010000) ? cpuPkg::aluSra : cpuPkg::aluSrl;
				immOk = (funct6 == 6'b000000) || (funct6 == 6'b010000);
			end
		endcase
	end

	always_comb begin
		rd         = '0;
		regWrite   = 1'b0;
		aluA       = '0;
		aluB       = '0;
		aluOp      = cpuPkg::aluAdd;
		memRead    = 1'b0;
		memWrite   = 1'b0;
		memSize    = cpuPkg::memNone;
		takeJump   = 1'b0;
		jumpTarget = '0;
		case (opcode)
			cpuPkg::opReg: if (regOk) begin
				rd       = instr[11:7];
				regWrite = 1'b1;
				aluA     = rs1Data;
				aluB     = rs2Data;
				aluOp    = regOp;
			end
			cpuPkg::opImm: if (immOk) begin
				rd       = instr[11:7];
				regWrite = 1'b1;
				aluA     = rs1Data;
				aluB     = immI; // shifts only see the low bits
				aluOp    = immOp;
			end
			cpuPkg::opLoad: if (funct3 != 3'b110 && funct3 != 3'b111) begin
				rd       = instr[11:7];
				regWrite = 1'b1;
				memRead  = 1'b1;
				memSize  = cpuPkg::memSizeT'(funct3);
				aluA     = rs1Data;
				aluB     = immI;
			end
			cpuPkg::opStore: if (funct3[2] == 1'b0) begin
				memWrite = 1'b1;
				memSize  = cpuPkg::memSizeT'(funct3);
				aluA     = rs1Data;
				aluB     = immS;
			end
			cpuPkg::opBranch: begin
				jumpTarget = pc + immB;
				case (funct3)
					3'b000:  takeJump = rs1Data == rs2Data;
					3'b001:  takeJump = rs1Data != rs2Data;
					3'b100:  takeJump = $signed(rs1Data) < $signed(rs2Data);
					3'b101:  takeJump = $signed(rs1Data) >= $signed(rs2Data);
					3'b110:  takeJump = rs1Data < rs2Data;
					3'b111:  takeJump = rs1Data >= rs2Data;
					default: takeJump = 1'b0;
				endcase
			end
			cpuPkg::opJal: begin
				rd         = instr[11:7];
				regWrite   = 1'b1;
				aluA       = pc; // link is pc+4
				aluB       = `XLEN'd4;
				takeJump   = 1'b1;
				jumpTarget = pc + immJ;
			end
			cpuPkg::opJalr: if (funct3 == 3'b000) begin
				rd         = instr[11:7];
				regWrite   = 1'b1;
				aluA       = pc;
				aluB       = `XLEN'd4;
				takeJump   = 1'b1;
				jumpTarget = (rs1Data + immI) & ~`XLEN'd1;
			end
			cpuPkg::opLui: begin
				rd       = instr[11:7];
				regWrite = 1'b1;
				aluB     = immU;
			end
			cpuPkg::opAuipc: begin
				rd       = instr[11:7];
				regWrite = 1'b1;
				aluA     = pc;
				aluB     = immU;
			end
			default: ; // unknown opcode is a no-op
		endcase
	end

endmodule

`default_nettype wire

//--- verilog/cpuCore.sv
`default_nettype none
`include "cpu_cfg.svh"

module cpuCore (
	input  logic                clk,
	input  logic                rst,
	input  logic [`INSTR_W-1:0] instr,
	output logic [`XLEN-1:0]    pc,
	output logic [`XLEN-1:0]    dataAddr,
	output logic [`XLEN-1:0]    dataOut,
	input  logic [`XLEN-1:0]    dataIn,
	output logic                memRead,
	output logic                memWrite,
	output cpuPkg::memSizeT     memSize
);

	logic [`INSTR_W-1:0] instrLive;
	logic [`REG_ADDR_W-1:0] rs1, rs2, rd;
	logic [`XLEN-1:0] rs1Data, rs2Data, aluA, aluB, aluResult;
	logic [`XLEN-1:0] loadData, writeData, jumpTarget, nextPc;
	logic regWrite, takeJump;
	cpuPkg::aluOpT aluOp;

	assign instrLive = rst ? '0 : instr; // zero decodes as a no-op
	assign nextPc    = takeJump ? jumpTarget : pc + `XLEN'd4;
	assign writeData = memRead ? loadData : aluResult;
	assign dataAddr  = aluResult;

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			pc <= `RESET_PC;
		end else begin
			pc <= nextPc;
		end
	end

	decoder uDecoder (
		.instr      (instrLive),
		.pc         (pc),
		.rs1        (rs1),
		.rs2        (rs2),
		.rs1Data    (rs1Data),
		.rs2Data    (rs2Data),
		.rd         (rd),
		.regWrite   (regWrite),
		.aluA       (aluA),
		.aluB       (aluB),
		.aluOp      (aluOp),
		.memRead    (memRead),
		.memWrite   (memWrite),
		.memSize    (memSize),
		.takeJump   (takeJump),
		.jumpTarget (jumpTarget)
	);

	registerFile uRegFile (
		.clk       (clk),
		.rst       (rst),
		.rs1       (rs1),
		.rs2       (rs2),
		.rd        (rd),
		.regWrite  (regWrite),
		.writeData (writeData),
		.rs1Data   (rs1Data),
		.rs2Data   (rs2Data)
	);

	alu uAlu (
		.a      (aluA),
		.b      (aluB),
		.op     (aluOp),
		.result (aluResult)
	);

	memFormat uMemFormat (
		.memSize  (memSize),
		.storeSrc (rs2Data),
		.dataOut  (dataOut),
		.dataIn   (dataIn),
		.loadData (loadData)
	);

endmodule

`default_nettype wire

//--- testbench/cpuChecker.sv
`default_nettype none
`include "cpu_cfg.svh"

module cpuChecker (
	input logic               clk,
	input logic               rst,
	input logic [`XLEN-1:0]   pc,
	input logic [`XLEN-1:0]   dataOut,
	input logic               memRead,
	input logic               memWrite,
	input cpuPkg::memSizeT    memSize
);

	int unsigned failures = 0; // failed bus assertions

	noReadWithWrite: assert property (@(posedge clk) !(memRead && memWrite))
		else begin
			failures++;
			$error("memRead and memWrite high in the same cycle");
		end

	quietInReset: assert property (@(posedge clk)
		rst |-> (!memRead && !memWrite && pc == `RESET_PC))
		else begin
			failures++;
			$error("bus strobes active or pc moved during reset");
		end

	pcAligned: assert property (@(posedge clk) pc[1:0] == 2'b00)
		else begin
			failures++;
			$error("pc not word aligned");
		end

	byteLanes: assert property (@(posedge clk) disable iff (rst)
		(memWrite && memSize == cpuPkg::memByte) |-> dataOut == {8{dataOut[7:0]}})
		else begin
			failures++;
			$error("byte store not replicated on every lane");
		end

	halfLanes: assert property (@(posedge clk) disable iff (rst)
		(memWrite && memSize == cpuPkg::memHalf) |-> dataOut == {4{dataOut[15:0]}})
		else begin
			failures++;
			$error("half store not replicated on every lane");
		end

	wordLanes: assert property (@(posedge clk) disable iff (rst)
		(memWrite && memSize == cpuPkg::memWord) |-> dataOut == {2{dataOut[31:0]}})
		else begin
			failures++;
			$error("word store not replicated on both lanes");
		end

endmodule

bind cpuCore cpuChecker uChecker (
	.clk      (clk),
	.rst      (rst),
	.pc       (pc),
	.dataOut  (dataOut),
	.memRead  (memRead),
	.memWrite (memWrite),
	.memSize  (memSize)
);

`default_nettype wire

//--- testbench/cpuTb.sv
`default_nettype none
`include "cpu_cfg.svh"

module cpuTb;

	localparam int resetCycles = 16;
	localparam int poisonAddr = 1016;

	logic clk = 1'b0;
	logic rst;
	logic [`INSTR_W-1:0] instr;
	logic [`XLEN-1:0] pc, dataAddr, dataOut, dataIn;
	logic memRead, memWrite;
	cpuPkg::memSizeT memSize;

	logic [31:0] imem [0:511];
	logic [7:0] dmem [0:1023];
	logic [63:0] expAddr [$];
	logic [63:0] expData [$];
	logic [63:0] haltPc, lastPc = '1;
	logic seenReset = 1'b0;
	int at = 0;
	int slot = 0;
	int errors = 0;
	int cycles = 0;
	int cycleLimit = 1000;

	// funct7 and funct3 per ALU op: add sub sll slt sltu seq sne xor srl sra or and
	int rF7 [12] = '{0, 'h30, 0, 0, 0, 1, 2, 0, 0, 'h20, 0, 0};
	int rF3 [12] = '{0, 0, 1, 2, 3, 2, 2, 4, 5, 5, 6, 7};
	int immK [9] = '{0, 3, 4, 7, 10, 11, 2, 8, 9};
	// beq bne blt bge bltu bgeu, each once true and once false
	int brF3 [6] = '{0, 1, 4, 5, 6, 7};
	int brA [12] = '{20, 20, 20, 20, 20, 21, 21, 20, 21, 20, 20, 21};
	int brB [12] = '{20, 21, 21, 20, 21, 20, 20, 21, 20, 21, 21, 20};

	cpuCore uut (
		.clk      (clk),
		.rst      (rst),
		.instr    (instr),
		.pc       (pc),
		.dataAddr (dataAddr),
		.dataOut  (dataOut),
		.dataIn   (dataIn),
		.memRead  (memRead),
		.memWrite (memWrite),
		.memSize  (memSize)
	);

	always #2 clk = ~clk;

	assign instr = imem[pc[10:2]];

	always_comb begin
		for (int i = 0; i < 8; i++) begin
			dataIn[8*i +: 8] = dmem[dataAddr[9:0] + 10'(i)];
		end
	end

	always @(posedge clk) begin
		if (memWrite) begin
			for (int i = 0; i < (1 << memSize[1:0]); i++) begin
				dmem[dataAddr[9:0] + 10'(i)] <= dataOut[8*i +: 8];
			end
		end
	end

	function automatic logic [31:0] rType(input int f7, input int rs2, input int rs1,
		input int f3, input int rd);
		return {7'(f7), 5'(rs2), 5'(rs1), 3'(f3), 5'(rd), cpuPkg::opReg};
	endfunction

	function automatic logic [31:0] iType(input int imm, input int rs1, input int f3,
		input int rd, input logic [6:0] op);
		return {12'(imm), 5'(rs1), 3'(f3), 5'(rd), op};
	endfunction

	function automatic logic [31:0] sType(input int imm, input int rs2, input int rs1,
		input int f3);
		logic [11:0] i;
		i = 12'(imm);
		return {i[11:5], 5'(rs2), 5'(rs1), 3'(f3), i[4:0], cpuPkg::opStore};
	endfunction

	function automatic logic [31:0] bType(input int imm, input int rs2, input int rs1,
		input int f3);
		logic [12:0] i;
		i = 13'(imm);
		return {i[12], i[10:5], 5'(rs2), 5'(rs1), 3'(f3), i[4:1], i[11], cpuPkg::opBranch};
	endfunction

	function automatic logic [31:0] uType(input int imm, input int rd, input logic [6:0] op);
		return {20'(imm), 5'(rd), op};
	endfunction

	function automatic logic [31:0] jType(input int imm, input int rd);
		logic [20:0] i;
		i = 21'(imm);
		return {i[20], i[10:1], i[11], i[19:12], 5'(rd), cpuPkg::opJal};
	endfunction

	// two's complement order from the sign bits, then magnitude
	function automatic logic signedLess(input logic [63:0] a, input logic [63:0] b);
		return (a[63] != b[63]) ? a[63] : (a < b);
	endfunction

	function automatic logic [63:0] aluRef(input int k, input logic [63:0] a,
		input logic [63:0] b);
		case (k)
			0:  return a + b;
			1:  return a - b;
			2:  return a << b[5:0];
			3:  return signedLess(a, b) ? 64'd1 : 64'd0;
			4:  return (a < b) ? 64'd1 : 64'd0;
			5:  return (a == b) ? 64'd1 : 64'd0;
			6:  return (a != b) ? 64'd1 : 64'd0;
			7:  return a ^ b;
			8:  return a >> b[5:0];
			9:  return (a >> b[5:0]) |
				(a[63] ? ~(64'hFFFF_FFFF_FFFF_FFFF >> b[5:0]) : 64'd0); // sign fill
			10: return a | b;
			default: return a & b;
		endcase
	endfunction

	function automatic logic [63:0] loadRef(input int f3, input logic [63:0] d);
		case (f3)
			0: return {{56{d[7]}}, d[7:0]};
			1: return {{48{d[15]}}, d[15:0]};
			2: return {{32{d[31]}}, d[31:0]};
			3: return d;
			4: return {56'b0, d[7:0]};
			default: return {48'b0, d[15:0]};
		endcase
	endfunction

	function automatic logic branchRef(input int f3, input logic [63:0] a,
		input logic [63:0] b);
		case (f3)
			0: return a == b;
			1: return a != b;
			4: return signedLess(a, b);
			5: return !signedLess(a, b);
			6: return a < b;
			default: return a >= b;
		endcase
	endfunction

	task automatic emit(input logic [31:0] w);
		imem[at] = w;
		at++;
	endtask

	task automatic expectStore(input logic [63:0] addr, input logic [63:0] data);
		expAddr.push_back(addr);
		expData.push_back(data);
	endtask

	// sd rs to the next free slot
	task automatic storeResult(input int rs, input logic [63:0] exp);
		emit(sType(slot, rs, 0, 3));
		expectStore(64'(slot), exp);
		slot += 8;
	endtask

	// lui then addi, value follows the RV64 sign extension of both
	task automatic loadConst(input int rd, input logic [31:0] v, output logic [63:0] val);
		logic [19:0] hi;
		logic [11:0] lo;
		hi = 20'((v + 32'h800) >> 12);
		lo = v[11:0];
		emit(uType(int'(hi), rd, cpuPkg::opLui));
		emit(iType(int'(lo), rd, 0, rd, cpuPkg::opImm));
		val = {{32{hi[19]}}, hi, 12'b0} + {{52{lo[11]}}, lo};
	endtask

	task automatic checkStore();
		logic [63:0] ea, ed;
		assert (expAddr.size() != 0) else begin
			errors++;
			$display("unexpected store to address %h after all expected stores", dataAddr);
		end
		if (expAddr.size() != 0) begin
			ea = expAddr.pop_front();
			ed = expData.pop_front();
			assert (dataAddr == ea && dataOut == ed) else begin
				errors++;
				$display("[FAIL] %0t store addr %h data %h, expected addr %h data %h",
					$time, dataAddr, dataOut, ea, ed);
			end
		end
	endtask

	task automatic finishRun();
		int chk;
		chk = int'(uut.uChecker.failures);
		$display("errors: %0d store checks, %0d bus assertions", errors, chk);
		if (errors == 0 && chk == 0) begin
			$display("TEST OK");
		end else begin
			$display("TEST FAILED");
		end
		$finish;
	endtask

	initial begin
		logic [63:0] a, b, c, v, d, bn, bp, poison, mark;
		logic [11:0] immV;
		int k, imm, pos, base, u;
		void'($urandom(32'h2a83));
		rst <= 1'b1;
		for (int i = 0; i < 512; i++) begin
			imem[i] = iType(i, 0, 0, 0, cpuPkg::opImm); // addi x0 filler
		end
		for (int i = 0; i < 1024; i++) begin
			dmem[i] <= 8'(i ^ (i >> 8) ^ 'hA5);
		end
		for (int j = 0; j < 12; j++) begin // register ops on random operands
			loadConst(5, $urandom, a);
			loadConst(6, $urandom, b);
			emit(rType(rF7[j], 6, 5, rF3[j], 7));
			storeResult(7, aluRef(j, a, b));
		end
		for (int j = 5; j < 7; j++) begin // seq and sne on equal operands
			emit(rType(rF7[j], 5, 5, rF3[j], 7));
			storeResult(7, aluRef(j, a, a));
		end
		foreach (immK[j]) begin
			k = immK[j];
			loadConst(5, $urandom, a);
			imm = int'($urandom & 32'hFFF);
			if (k == 2 || k == 8) imm = imm & 63;
			if (k == 9) imm = 'h400 | (imm & 63); // srai marker in imm[11:6]
			immV = 12'(imm);
			emit(iType(imm, 5, rF3[k], 7, cpuPkg::opImm));
			storeResult(7, aluRef(k, a, {{52{immV[11]}}, immV}));
		end
		// sb, sh, sw into a known doubleword, then read it back
		loadConst(8, $urandom, c);
		loadConst(9, $urandom, v);
		pos = slot;
		storeResult(9, v);
		emit(sType(pos + 1, 8, 0, 0));
		expectStore(64'(pos + 1), {8{c[7:0]}});
		emit(sType(pos + 2, 8, 0, 1));
		expectStore(64'(pos + 2), {4{c[15:0]}});
		emit(sType(pos + 4, 8, 0, 2));
		expectStore(64'(pos + 4), {2{c[31:0]}});
		emit(iType(pos, 0, 3, 10, cpuPkg::opLoad));
		storeResult(10, {c[31:0], c[15:0], c[7:0], v[7:0]});
		// loads of data with the top bit of every lane set
		loadConst(11, $urandom | 32'h8000_8080, d);
		pos = slot;
		storeResult(11, d);
		for (int f = 0; f < 6; f++) begin
			emit(iType(pos, 0, f, 12, cpuPkg::opLoad));
			storeResult(12, loadRef(f, d));
		end
		loadConst(20, -5, bn);
		loadConst(21, 7, bp);
		loadConst(22, 32'hDEAD_BEEF, poison);
		loadConst(23, 32'h1234_5678, mark);
		for (int t = 0; t < 12; t++) begin // taken branch skips the poison store
			emit(bType(8, brB[t], brA[t], brF3[t / 2]));
			emit(sType(poisonAddr, 22, 0, 3));
			if (!branchRef(brF3[t / 2], brA[t] == 20 ? bn : bp, brB[t] == 20 ? bn : bp)) begin
				expectStore(64'(poisonAddr), poison);
			end
			storeResult(23, mark);
		end
		base = at * 4;
		emit(jType(8, 16));
		emit(sType(poisonAddr, 22, 0, 3));
		storeResult(16, 64'(base + 4));
		base = at * 4;
		u = int'($urandom & 32'hFFFFF);
		emit(uType(u, 17, cpuPkg::opAuipc));
		storeResult(17, 64'(base) + {{32{u[19]}}, 20'(u), 12'b0});
		base = at * 4;
		emit(uType(0, 18, cpuPkg::opAuipc));
		emit(iType(17, 18, 0, 19, cpuPkg::opJalr)); // odd offset, bit 0 dropped
		emit(sType(poisonAddr, 22, 0, 3));
		emit(sType(poisonAddr, 22, 0, 3));
		storeResult(19, 64'(base + 8));
		emit(iType('h7B, 0, 0, 0, cpuPkg::opImm)); // write to x0
		storeResult(0, 64'd0);
		haltPc = 64'(at * 4);
		emit(jType(0, 0));
		cycleLimit = resetCycles + at + 64;
		repeat (resetCycles) @(posedge clk);
		rst <= 1'b0;
	end

	always @(negedge clk) begin
		if (rst) begin
			seenReset = 1'b1;
		end else if (pc == haltPc && lastPc == haltPc) begin
			assert (expAddr.size() == 0) else begin
				errors++;
				$display("program halted with %0d expected stores never seen", expAddr.size());
			end
			finishRun();
		end else begin
			if (seenReset) begin // first fetch after release
				assert (pc == `RESET_PC) else begin
					errors++;
					$display("[FAIL] %0t first fetch after reset at pc %h", $time, pc);
				end
			end
			seenReset = 1'b0;
			if (memWrite) checkStore();
			lastPc = pc;
		end
	end

	always @(posedge clk) begin
		cycles++;
		if (cycles >= cycleLimit) begin
			errors++;
			$display("timeout: program did not reach its halt loop in %0d cycles", cycles);
			finishRun();
		end
	end

endmodule

`default_nettype wire

//--- build.f
+incdir+verilog
verilog/cpuPkg.sv
verilog/registerFile.sv
verilog/alu.sv
verilog/memFormat.sv
verilog/decoder.sv
verilog/cpuCore.sv
testbench/cpuChecker.sv
testbench/cpuTb.sv

//--- run.sh
#!/bin/sh
rm -rf obj_dir sim.log
verilator --binary --assert --top-module cpuTb -f build.f -Mdir obj_dir -o cpuSim \
	&& ./obj_dir/cpuSim +verilator+error+limit+1000 > sim.log 2>&1
cat sim.log 2>/dev/null
grep -q "TEST FAILED" sim.log && exit 1 || grep -q "TEST OK" sim.log
